// ==== Makefile ====
# Verilator build and run of the multiply/divide unit testbench

SIM      ?= verilator
TOP      ?= tb_muldiv
FILELIST ?= verilog.f
BUILD    ?= obj_dir
SIMFLAGS ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM) and run $(TOP), status is pass or fail"
	@echo "  clean  remove $(BUILD)"
	@echo "variables: SIM TOP FILELIST BUILD SIMFLAGS"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== bench/clk_gen.sv ====
`default_nettype none

module clk_gen (
	output logic aclk,
	output logic aresetn
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int half_period = 4;	// 8 ns clock
	localparam int reset_cycles = 4;

	initial begin
		aclk = 1'b0;
		forever #half_period aclk = ~aclk;
	end

	// release on a falling edge, away from the active edge
	initial begin
		aresetn = 1'b0;
		repeat (reset_cycles) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/tb_muldiv.sv ====
`default_nettype none

module tb_muldiv import muldiv_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int mul_lat = 5;		// completion edge after acceptance
	localparam int div_lat = 33;	// load edge plus 32 steps
	localparam int wait_limit = 100;

	logic       aclk;
	logic       aresetn;
	logic       start;
	muldiv_op_e op;
	word_t      src_a;
	word_t      src_b;
	logic       hilo_wr;
	logic       hilo_wr_hi;
	logic       hilo_rd_hi;
	logic       busy;
	word_t      hilo_rd_data;
	word_t      mul_result;
	logic       mul_valid;

	word_t       model_hi;	// expected register contents
	word_t       model_lo;
	logic [31:0] lcg_state;

	clk_gen u_clk_gen (
		.aclk    (aclk),
		.aresetn (aresetn)
	);

	muldiv_unit DUT (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.start        (start),
		.op           (op),
		.src_a        (src_a),
		.src_b        (src_b),
		.hilo_wr      (hilo_wr),
		.hilo_wr_hi   (hilo_wr_hi),
		.hilo_rd_hi   (hilo_rd_hi),
		.busy         (busy),
		.hilo_rd_data (hilo_rd_data),
		.mul_result   (mul_result),
		.mul_valid    (mul_valid)
	);

	task automatic fail_value(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Test failures found");
		$fatal(1, "value check failed");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	function automatic word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// about one operand in four is a corner value
	function automatic word_t pick_operand();
		word_t r;
		r = next_rand();
		if (r[31:30] != 2'b00)
			return next_rand();
		case (r[29:28])
			2'd0: return 32'h0000_0000;
			2'd1: return 32'hffff_ffff;	// all ones or minus one
			2'd2: return 32'h8000_0000;	// most negative
			default: return 32'h7fff_ffff;
		endcase
	endfunction

	// expected {hi, lo} after an op
	function automatic dword_t expect_hilo(input muldiv_op_e o, input word_t a, input word_t b);
		dword_t old;
		dword_t prod_u;
		dword_t prod_s;
		word_t  q;
		word_t  r;
		old = {model_hi, model_lo};
		prod_u = {32'd0, a} * {32'd0, b};
		prod_s = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		case (o)
			op_multu: return prod_u;
			op_mult, op_mul: return prod_s;	// mul keeps only the low word
			op_maddu: return old + prod_u;
			op_madd: return old + prod_s;
			op_msubu: return old - prod_u;
			op_msub: return old - prod_s;
			op_divu: begin
				q = a / b;
				r = a % b;
				return {r, q};
			end
			default: begin
				if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
					q = a;	// overflow wraps back to the dividend
					r = '0;
				end else begin
					q = word_t'($signed(a) / $signed(b));
					r = word_t'($signed(a) % $signed(b));
				end
				return {r, q};
			end
		endcase
	endfunction

	task automatic write_hilo(input logic to_hi, input word_t data);
		@(negedge aclk);
		hilo_wr = 1'b1;
		hilo_wr_hi = to_hi;
		src_a = data;
		@(negedge aclk);
		hilo_wr = 1'b0;
		if (to_hi)
			model_hi = data;
		else
			model_lo = data;
	endtask

	// read both words through the select and compare with the model
	task automatic check_hilo(input string what);
		word_t hi;
		word_t lo;
		@(negedge aclk);
		hilo_rd_hi = 1'b1;
		@(negedge aclk);
		hi = hilo_rd_data;
		hilo_rd_hi = 1'b0;
		@(negedge aclk);
		lo = hilo_rd_data;
		assert (hi == model_hi)
			else fail_value($sformatf("%s: HI %h, expected %h", what, hi, model_hi));
		assert (lo == model_lo)
			else fail_value($sformatf("%s: LO %h, expected %h", what, lo, model_lo));
		assert (!busy)
			else fail_value($sformatf("%s: unit busy with no op started", what));
	endtask

	task automatic run_op(input muldiv_op_e o, input word_t a, input word_t b,
			input logic collide);
		dword_t exp;
		int     lat;
		int     cycles;
		logic   done;
		exp = expect_hilo(o, a, b);
		lat = (o == op_div || o == op_divu) ? div_lat : mul_lat;
		cycles = 0;
		done = 1'b0;
		@(negedge aclk);
		op = o;
		src_a = a;
		src_b = b;
		start = 1'b1;
		while (!done) begin
			@(negedge aclk);
			cycles++;
			if (cycles > wait_limit)
				fail_plain($sformatf("timeout: %s never finished", o.name()));
			done = (o == op_mul) ? mul_valid : !busy;
			start = !done && cycles == 2;	// stray start while busy
			if (start) begin
				op = op_divu;
				src_a = next_rand();
				src_b = next_rand();
			end
			hilo_wr = !done && collide && cycles == lat;	// lands on the result edge
			if (hilo_wr) begin
				hilo_wr_hi = 1'b1;
				src_a = ~exp[63:32];
			end
		end
		hilo_wr = 1'b0;
		assert (cycles == lat + 1)
			else fail_value($sformatf("%s finished after %0d cycles, expected %0d",
				o.name(), cycles, lat + 1));
		if (o == op_mul) begin
			assert (!busy)
				else fail_value($sformatf("%s: busy still high at completion", o.name()));
			assert (mul_result == exp[31:0])
				else fail_value($sformatf("mul %h * %h gave %h, expected %h",
					a, b, mul_result, exp[31:0]));
		end else begin
			model_hi = exp[63:32];
			model_lo = exp[31:0];
		end
		check_hilo($sformatf("%s %h %h", o.name(), a, b));
	endtask

	initial begin
		int    n;
		word_t b;
		lcg_state = 32'h8937_8b58;
		start = 1'b0;
		op = op_multu;
		src_a = '0;
		src_b = '0;
		hilo_wr = 1'b0;
		hilo_wr_hi = 1'b0;
		hilo_rd_hi = 1'b0;
		model_hi = '0;
		model_lo = '0;
		n = 0;
		while (aresetn !== 1'b1) begin
			@(negedge aclk);
			n++;
			if (n > 20)
				fail_plain("reset was never released");
		end

		assert (!busy && !mul_valid)
			else fail_value("busy or mul_valid high after reset");
		check_hilo("after reset");

		write_hilo(1'b1, 32'hdead_beef);
		write_hilo(1'b0, 32'h1234_5678);
		check_hilo("direct writes");

		// direct write on the completion edge loses to the result
		run_op(op_mult, 32'h0001_0000, 32'hffff_fff0, 1'b1);
		run_op(op_mult, 32'h8000_0000, 32'h8000_0000, 1'b0);
		run_op(op_multu, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
		run_op(op_mult, 32'hffff_ffff, 32'h8000_0000, 1'b0);
		for (n = 0; n < 10; n++) begin
			run_op(op_mult, pick_operand(), pick_operand(), 1'b0);
			run_op(op_multu, pick_operand(), pick_operand(), n[0]);
		end

		// wrap of the 64-bit accumulator
		write_hilo(1'b1, 32'hffff_ffff);
		write_hilo(1'b0, 32'hffff_ffff);
		run_op(op_maddu, 32'd1, 32'd1, 1'b0);
		for (n = 0; n < 6; n++) begin
			write_hilo(1'b1, next_rand());
			write_hilo(1'b0, next_rand());
			run_op(op_madd, pick_operand(), pick_operand(), 1'b0);
			run_op(op_maddu, pick_operand(), pick_operand(), 1'b0);
			run_op(op_msub, pick_operand(), pick_operand(), 1'b0);
			run_op(op_msubu, pick_operand(), pick_operand(), 1'b0);
		end

		for (n = 0; n < 8; n++)
			run_op(op_mul, pick_operand(), pick_operand(), 1'b0);

		run_op(op_div, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_op(op_div, 32'hffff_fff9, 32'd2, 1'b0);	// -7 / 2
		for (n = 0; n < 8; n++) begin
			b = pick_operand();
			if (b == '0)
				b = 32'd7;
			run_op(op_div, pick_operand(), b, n == 3);
			run_op(op_divu, pick_operand(), b, 1'b0);
		end

		@(negedge aclk);
		$display("All tests passed!");
		$finish;
	end

	// mul_valid is a single-cycle pulse
	assert property (@(posedge aclk) disable iff (!aresetn) !(mul_valid && $past(mul_valid)))
		else fail_value("mul_valid high for more than one cycle");

	assert property (@(posedge aclk) disable iff (!aresetn) !(mul_valid && busy))
		else fail_value("mul_valid raised while busy");

endmodule

`default_nettype wire

// ==== rtl/div_iter.sv ====
`default_nettype none

module div_iter import muldiv_pkg::*; (
	input  logic  aclk,
	input  logic  aresetn,
	input  logic  div_start,
	input  logic  div_signed,
	input  word_t src_a,
	input  word_t src_b,
	output word_t quotient,
	output word_t remainder,
	output logic  div_done
);

	word_t rem_q;		// partial remainder
	word_t quo_q;		// dividend shifting out, quotient shifting in
	word_t dsr_q;		// divisor magnitude
	logic  neg_quo;
	logic  neg_rem;
	logic  running;
	lat_t  step;

	logic        a_neg;
	logic        b_neg;
	word_t       a_mag;
	word_t       b_mag;
	logic [32:0] diff;

	assign a_neg = div_signed & src_a[31];
	assign b_neg = div_signed & src_b[31];
	// magnitude of the most negative value still fits unsigned
	assign a_mag = a_neg ? -src_a : src_a;
	assign b_mag = b_neg ? -src_b : src_b;

	// trial subtract, bit 32 set means it went negative
	assign diff = {rem_q, quo_q[31]} - {1'b0, dsr_q};

	always_ff @(posedge aclk) begin
		if (div_start) begin
			rem_q <= '0;
			quo_q <= a_mag;
			dsr_q <= b_mag;
			neg_quo <= a_neg ^ b_neg;
			neg_rem <= a_neg;	// remainder follows the dividend
		end else if (running) begin
			if (diff[32]) begin
				rem_q <= {rem_q[30:0], quo_q[31]};	// restore
				quo_q <= {quo_q[30:0], 1'b0};
			end else begin
				rem_q <= diff[31:0];
				quo_q <= {quo_q[30:0], 1'b1};
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			running <= 1'b0;
			step <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			if (div_start) begin
				running <= 1'b1;
				step <= '0;
			end else if (running) begin
				step <= step + 1'b1;
				if (step == lat_t'(div_steps - 1)) begin
					running <= 1'b0;
					div_done <= 1'b1;	// single-cycle pulse
				end
			end
		end
	end

	// sign fixup, held until the next load
	assign quotient = neg_quo ? -quo_q : quo_q;
	assign remainder = neg_rem ? -rem_q : rem_q;

endmodule

`default_nettype wire

// ==== rtl/hilo_regs.sv ====
`default_nettype none

module hilo_regs import muldiv_pkg::*; (
	input  logic   aclk,
	input  logic   aresetn,
	input  logic   result_we,
	input  dword_t result,
	input  logic   hilo_wr,
	input  logic   hilo_wr_hi,
	input  word_t  src_a,
	input  logic   hilo_rd_hi,
	output dword_t hilo,
	output word_t  hilo_rd_data
);

	word_t hi_q;
	word_t lo_q;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			hi_q <= '0;
			lo_q <= '0;
		end else if (result_we) begin
			// a finishing op beats a mthi/mtlo in the same cycle
			hi_q <= result[63:32];
			lo_q <= result[31:0];
		end else if (hilo_wr) begin
			if (hilo_wr_hi)
				hi_q <= src_a;
			else
				lo_q <= src_a;
		end
	end

	assign hilo = {hi_q, lo_q};
	assign hilo_rd_data = hilo_rd_hi ? hi_q : lo_q;	// mfhi / mflo

endmodule

`default_nettype wire

// ==== rtl/mul_pipe.sv ====
`default_nettype none

module mul_pipe import muldiv_pkg::*; (
	input  logic   aclk,
	input  logic   aresetn,
	input  logic   mul_start,
	input  logic   mul_signed,
	input  word_t  src_a,
	input  word_t  src_b,
	output dword_t product,
	output logic   product_valid
);

	logic signed [32:0] a_q;	// extended operands, stage 0
	logic signed [32:0] b_q;
	dword_t prod_q [1:mul_stages-1];
	logic [mul_stages-1:0] valid_q;

	// one extra bit makes both signed and unsigned a signed multiply
	always_ff @(posedge aclk) begin
		if (mul_start) begin
			a_q <= {mul_signed & src_a[31], src_a};
			b_q <= {mul_signed & src_b[31], src_b};
		end
	end

	// low 64 bits of the 66-bit product are exact for both forms
	always_ff @(posedge aclk) begin
		prod_q[1] <= 64'(a_q) * 64'(b_q);
		for (int i = 2; i < mul_stages; i++)
			prod_q[i] <= prod_q[i-1];	// balance stages for retiming
	end

	always_ff @(posedge aclk) begin
		if (!aresetn)
			valid_q <= '0;
		else
			valid_q <= {valid_q[mul_stages-2:0], mul_start};
	end

	assign product = prod_q[mul_stages-1];
	assign product_valid = valid_q[mul_stages-1];

endmodule

`default_nettype wire

// ==== rtl/muldiv_ctrl.sv ====
`default_nettype none

module muldiv_ctrl import muldiv_pkg::*; (
	input  logic       aclk,
	input  logic       aresetn,
	input  logic       start,
	input  muldiv_op_e op,
	output logic       busy,
	output logic       mul_start,
	output logic       mul_signed,
	output logic       div_start,
	output logic       div_signed,
	input  dword_t     product,
	input  logic       product_valid,
	input  word_t      quotient,
	input  word_t      remainder,
	input  logic       div_done,
	input  dword_t     hilo,
	output logic       result_we,
	output dword_t     result,
	output word_t      mul_result,
	output logic       mul_valid
);

	ctrl_state_e state;
	muldiv_op_e  op_q;		// operation in flight
	dword_t      hilo_q;	// hi/lo as seen at acceptance
	lat_t        lat_cnt;	// cycles left until the result is due

	logic accept;
	logic op_is_div;
	logic op_signed;
	logic mul_done;
	logic div_fin;

	// class and signedness of the incoming op
	always_comb begin
		op_is_div = 1'b0;
		op_signed = 1'b0;
		case (op)
			op_mult, op_madd, op_msub, op_mul: begin
				op_signed = 1'b1;
			end
			op_div: begin
				op_is_div = 1'b1;
				op_signed = 1'b1;
			end
			op_divu: begin
				op_is_div = 1'b1;
			end
			default: begin
				op_signed = 1'b0;	// remaining unsigned multiplies
			end
		endcase
	end

	assign accept = start && (state == idle);	// starts while busy are dropped
	assign busy = (state != idle);

	assign mul_start = accept && !op_is_div;
	assign mul_signed = op_signed;
	assign div_start = accept && op_is_div;
	assign div_signed = op_signed;

	// a valid only counts once the expected latency has run out
	assign mul_done = (state == mul_busy) && product_valid && (lat_cnt == '0);
	assign div_fin = (state == div_busy) && div_done && (lat_cnt == '0);

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= idle;
			lat_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (accept && op_is_div) begin
						state <= div_busy;
						lat_cnt <= lat_t'(div_steps);
					end else if (accept) begin
						state <= mul_busy;
						lat_cnt <= lat_t'(mul_stages - 1);
					end
				end
				mul_busy: begin
					if (mul_done)
						state <= idle;
				end
				div_busy: begin
					if (div_fin)
						state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
			if (state != idle && lat_cnt != '0)
				lat_cnt <= lat_cnt - 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn)
			op_q <= op_multu;
		else if (accept)
			op_q <= op;
	end

	// snapshot for madd/msub, later direct writes do not disturb it
	always_ff @(posedge aclk) begin
		if (accept)
			hilo_q <= hilo;
	end

	always_comb begin
		case (op_q)
			op_madd, op_maddu: result = hilo_q + product;
			op_msub, op_msubu: result = hilo_q - product;
			op_div, op_divu:   result = {remainder, quotient};	// hi gets the remainder
			default:           result = product;
		endcase
	end

	assign result_we = (mul_done && op_q != op_mul) || div_fin;

	// three-operand mul bypasses hi/lo
	always_ff @(posedge aclk) begin
		if (!aresetn)
			mul_valid <= 1'b0;
		else
			mul_valid <= mul_done && (op_q == op_mul);
	end

	always_ff @(posedge aclk) begin
		if (mul_done)
			mul_result <= product[31:0];
	end

endmodule

`default_nettype wire

// ==== rtl/muldiv_pkg.sv ====
`default_nettype none

package muldiv_pkg;

	typedef logic [31:0] word_t;	// operand or register word
	typedef logic [63:0] dword_t;	// full product, or {hi, lo}

	// pipeline depth of the multiplier
	localparam int mul_stages = 5;
	// one quotient bit per iteration
	localparam int div_steps = 32;

	// wide enough to count a whole divide
	localparam int lat_w = $clog2(div_steps + 1);

	typedef logic [lat_w-1:0] lat_t;

	// encoding follows the core's alu2 op field
	typedef enum logic [3:0] {
		op_multu = 4'b0000,
		op_mult  = 4'b0001,
		op_divu  = 4'b0010,
		op_div   = 4'b0011,
		op_maddu = 4'b0100,
		op_madd  = 4'b0101,
		op_msub  = 4'b0110,
		op_msubu = 4'b0111,
		op_mul   = 4'b1000
	} muldiv_op_e;

	typedef enum logic [1:0] {
		idle,
		mul_busy,
		div_busy
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
	input  logic       aclk,
	input  logic       aresetn,
	input  logic       start,
	input  muldiv_op_e op,
	input  word_t      src_a,
	input  word_t      src_b,
	input  logic       hilo_wr,
	input  logic       hilo_wr_hi,
	input  logic       hilo_rd_hi,
	output logic       busy,
	output word_t      hilo_rd_data,
	output word_t      mul_result,
	output logic       mul_valid
);

	logic   mul_start;
	logic   mul_signed;
	logic   div_start;
	logic   div_signed;
	dword_t product;
	logic   product_valid;
	word_t  quotient;
	word_t  remainder;
	logic   div_done;
	logic   result_we;
	dword_t result;
	dword_t hilo;

	muldiv_ctrl u_ctrl (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.start         (start),
		.op            (op),
		.busy          (busy),
		.mul_start     (mul_start),
		.mul_signed    (mul_signed),
		.div_start     (div_start),
		.div_signed    (div_signed),
		.product       (product),
		.product_valid (product_valid),
		.quotient      (quotient),
		.remainder     (remainder),
		.div_done      (div_done),
		.hilo          (hilo),
		.result_we     (result_we),
		.result        (result),
		.mul_result    (mul_result),
		.mul_valid     (mul_valid)
	);

	mul_pipe u_mul (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.mul_start     (mul_start),
		.mul_signed    (mul_signed),
		.src_a         (src_a),
		.src_b         (src_b),
		.product       (product),
		.product_valid (product_valid)
	);

	div_iter u_div (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.div_start  (div_start),
		.div_signed (div_signed),
		.src_a      (src_a),
		.src_b      (src_b),
		.quotient   (quotient),
		.remainder  (remainder),
		.div_done   (div_done)
	);

	// src_a doubles as the mthi/mtlo data
	hilo_regs u_hilo (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.result_we    (result_we),
		.result       (result),
		.hilo_wr      (hilo_wr),
		.hilo_wr_hi   (hilo_wr_hi),
		.src_a        (src_a),
		.hilo_rd_hi   (hilo_rd_hi),
		.hilo         (hilo),
		.hilo_rd_data (hilo_rd_data)
	);

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/muldiv_pkg.sv
rtl/mul_pipe.sv
rtl/div_iter.sv
rtl/hilo_regs.sv
rtl/muldiv_ctrl.sv
rtl/muldiv_unit.sv
bench/clk_gen.sv
bench/tb_muldiv.sv
